/* exec_pkg.sv */
// ==============================
// exec_pkg: widths, encodings and
// payload types of the execute pipe
// ==============================
package exec_pkg;

  localparam int XLEN  = 32;
  localparam int IMM_W = 20;

  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    XOR = 4'd3,
    OR  = 4'd4,
    SHL = 4'd5,
    SHR = 4'd6,
    SAR = 4'd7,
    SXT = 4'd8,
    MOV = 4'd9
  } exec_opcode_e;  // 10..15 decode as MOV

  typedef enum logic [3:0] {
    EQ = 4'd0,
    NE = 4'd1,
    CS = 4'd2,
    CC = 4'd3,
    MI = 4'd4,
    PL = 4'd5,
    VS = 4'd6,
    VC = 4'd7,
    HI = 4'd8,
    LS = 4'd9,
    GE = 4'd10,
    LT = 4'd11,
    GT = 4'd12,
    LE = 4'd13,
    AL = 4'd14,
    NV = 4'd15
  } exec_cond_e;

  // register form, low field ignored
  typedef struct packed {
    exec_opcode_e     opcode;
    exec_cond_e       cond;
    logic             set_flags;
    logic             imm_form;
    logic [1:0]       size;
    logic [IMM_W-1:0] spare;
  } exec_insn_reg_t;

  // immediate form, sign-extended on decode
  typedef struct packed {
    exec_opcode_e     opcode;
    exec_cond_e       cond;
    logic             set_flags;
    logic             imm_form;
    logic [1:0]       size;
    logic [IMM_W-1:0] imm;
  } exec_insn_imm_t;

  typedef union packed {
    exec_insn_reg_t r;
    exec_insn_imm_t i;
  } exec_insn_u;

  typedef struct packed {
    logic c;
    logic v;
    logic s;
    logic z;
  } exec_flags_t;

  typedef struct packed {
    exec_insn_u      insn;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } exec_req_t;

  typedef struct packed {
    exec_opcode_e    opcode;
    exec_cond_e      cond;
    logic            set_flags;
    logic [1:0]      size;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b_sel;
  } exec_op_t;

  typedef struct packed {
    exec_cond_e      cond;
    logic            set_flags;
    logic [XLEN-1:0] result;
    exec_flags_t     cand;   // flags if the insn commits
  } exec_alu_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    exec_flags_t     flags;
    logic            executed;
  } exec_rsp_t;

endpackage

/* pipe_stage.sv */
// ==============================
// pipe_stage: one-entry valid/ready
// register, ready passed through
// ==============================
module pipe_stage #(
  parameter type T = logic [31:0]
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  // free, or the held item leaves this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

/* exec_decode.sv */
// ==============================
// exec_decode: stage 1, splits the
// insn word and picks operand b
// ==============================
module exec_decode (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  output logic               in_ready,
  input  exec_pkg::exec_req_t in_req,
  output logic               out_valid,
  input  logic               out_ready,
  output exec_pkg::exec_op_t  out_op
);
  import exec_pkg::*;

  exec_op_t     op_d;
  exec_opcode_e opc;

  always_comb begin
    op_d.a = in_req.a;
    if (in_req.insn.r.imm_form) begin
      opc            = in_req.insn.i.opcode;
      op_d.cond      = in_req.insn.i.cond;
      op_d.set_flags = in_req.insn.i.set_flags;
      op_d.size      = in_req.insn.i.size;
      op_d.b_sel     = {{(XLEN-IMM_W){in_req.insn.i.imm[IMM_W-1]}}, in_req.insn.i.imm};
    end else begin
      opc            = in_req.insn.r.opcode;
      op_d.cond      = in_req.insn.r.cond;
      op_d.set_flags = in_req.insn.r.set_flags;
      op_d.size      = in_req.insn.r.size;
      op_d.b_sel     = in_req.b;
    end
    // unassigned codes fold into mov
    if (opc > MOV) begin
      op_d.opcode = MOV;
    end else begin
      op_d.opcode = opc;
    end
  end

  pipe_stage #(
    .T(exec_op_t)
  ) u_stage (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (op_d),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_op)
  );

endmodule

/* exec_shift.sv */
// ==============================
// exec_shift: shifts, sign-extend
// and byte swap for the ALU
// ==============================
module exec_shift (
  input  exec_pkg::exec_opcode_e     opcode,
  input  logic [1:0]                 size,
  input  logic [exec_pkg::XLEN-1:0]  a,
  input  logic [4:0]                 amount,
  output logic [exec_pkg::XLEN-1:0]  result
);
  import exec_pkg::*;

  logic [XLEN-1:0] ext;

  always_comb begin
    case (size)
      2'd0:    ext = {{(XLEN-8){a[7]}}, a[7:0]};
      2'd1:    ext = {{(XLEN-16){a[15]}}, a[15:0]};
      2'd2:    ext = {{(XLEN-16){1'b0}}, a[15:0]};
      default: ext = {a[7:0], a[15:8], a[23:16], a[31:24]};  // byte swap
    endcase
  end

  always_comb begin
    case (opcode)
      SHL:     result = a << amount;
      SHR:     result = a >> amount;
      SAR:     result = $signed(a) >>> amount;
      SXT:     result = ext;
      default: result = a;
    endcase
  end

endmodule

/* exec_alu.sv */
// ==============================
// exec_alu: stage 2, result and
// candidate flags
// ==============================
module exec_alu (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  exec_pkg::exec_op_t  in_op,
  output logic                out_valid,
  input  logic                out_ready,
  output exec_pkg::exec_alu_t out_res
);
  import exec_pkg::*;

  exec_alu_t       res_d;
  logic [XLEN-1:0] shift_res;
  logic [XLEN-1:0] b_add;
  logic [XLEN:0]   sum;
  logic            sub;

  exec_shift u_shift (
    .opcode(in_op.opcode),
    .size  (in_op.size),
    .a     (in_op.a),
    .amount(in_op.b_sel[4:0]),
    .result(shift_res)
  );

  // sub is a + ~b + 1, carry out means no borrow
  assign sub   = (in_op.opcode == SUB);
  assign b_add = sub ? ~in_op.b_sel : in_op.b_sel;
  assign sum   = {1'b0, in_op.a} + {1'b0, b_add} + {{XLEN{1'b0}}, sub};

  always_comb begin
    res_d.cond      = in_op.cond;
    res_d.set_flags = in_op.set_flags;
    res_d.cand.c    = 1'b0;
    res_d.cand.v    = 1'b0;
    case (in_op.opcode)
      ADD, SUB: begin
        res_d.result = sum[XLEN-1:0];
        res_d.cand.c = sum[XLEN];
        res_d.cand.v = (in_op.a[XLEN-1] == b_add[XLEN-1]) &&
                       (sum[XLEN-1] != in_op.a[XLEN-1]);
      end
      AND:                res_d.result = in_op.a & in_op.b_sel;
      XOR:                res_d.result = in_op.a ^ in_op.b_sel;
      OR:                 res_d.result = in_op.a | in_op.b_sel;
      SHL, SHR, SAR, SXT: res_d.result = shift_res;
      default:            res_d.result = in_op.b_sel;  // mov
    endcase
    res_d.cand.s = res_d.result[XLEN-1];
    res_d.cand.z = (res_d.result == '0);
  end

  pipe_stage #(
    .T(exec_alu_t)
  ) u_stage (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (res_d),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_res)
  );

endmodule

/* exec_commit.sv */
// ==============================
// exec_commit: stage 3, flag reg,
// condition test and commit
// ==============================
module exec_commit (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  exec_pkg::exec_alu_t in_res,
  output logic                out_valid,
  input  logic                out_ready,
  output exec_pkg::exec_rsp_t out_rsp
);
  import exec_pkg::*;

  exec_flags_t flags_q;
  exec_flags_t flags_nxt;
  exec_rsp_t   rsp_d;
  logic        holds;

  always_comb begin
    case (in_res.cond)
      EQ:      holds = flags_q.z;
      NE:      holds = !flags_q.z;
      CS:      holds = flags_q.c;
      CC:      holds = !flags_q.c;
      MI:      holds = flags_q.s;
      PL:      holds = !flags_q.s;
      VS:      holds = flags_q.v;
      VC:      holds = !flags_q.v;
      HI:      holds = flags_q.c && !flags_q.z;
      LS:      holds = !flags_q.c || flags_q.z;
      GE:      holds = (flags_q.s == flags_q.v);
      LT:      holds = (flags_q.s != flags_q.v);
      GT:      holds = !flags_q.z && (flags_q.s == flags_q.v);
      LE:      holds = flags_q.z || (flags_q.s != flags_q.v);
      AL:      holds = 1'b1;
      default: holds = 1'b0;  // nv
    endcase
  end

  assign flags_nxt = (holds && in_res.set_flags) ? in_res.cand : flags_q;

  assign rsp_d.result   = in_res.result;
  assign rsp_d.flags    = flags_nxt;
  assign rsp_d.executed = holds;

  // flags move as the item enters, so commit order is program order
  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q <= '0;
    end else if (in_valid && in_ready) begin
      flags_q <= flags_nxt;
    end
  end

  pipe_stage #(
    .T(exec_rsp_t)
  ) u_stage (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (rsp_d),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_rsp)
  );

endmodule

/* exec_top.sv */
// ==============================
// exec_top: three-stage execute
// pipeline, decode/alu/commit
// ==============================
module exec_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  exec_pkg::exec_req_t in_req,
  output logic                out_valid,
  input  logic                out_ready,
  output exec_pkg::exec_rsp_t out_rsp
);
  import exec_pkg::*;

  exec_op_t  dec_op;
  exec_alu_t alu_res;
  logic      dec_valid;
  logic      dec_ready;
  logic      alu_valid;
  logic      alu_ready;

  exec_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_req   (in_req),
    .out_valid(dec_valid),
    .out_ready(dec_ready),
    .out_op   (dec_op)
  );

  exec_alu u_alu (
    .clk      (clk),
    .rst      (rst),
    .in_valid (dec_valid),
    .in_ready (dec_ready),
    .in_op    (dec_op),
    .out_valid(alu_valid),
    .out_ready(alu_ready),
    .out_res  (alu_res)
  );

  exec_commit u_commit (
    .clk      (clk),
    .rst      (rst),
    .in_valid (alu_valid),
    .in_ready (alu_ready),
    .in_res   (alu_res),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_rsp  (out_rsp)
  );

endmodule

/* tb_model.svh */
// ==============================
// tb_model: reference model of the
// execute pipe for the testbench
// ==============================
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic bit model_cond(input int cond, input exec_pkg::exec_flags_t f);
  bit ge;
  ge = (f.s == f.v);
  case (cond)
    0:  return f.z;
    1:  return !f.z;
    2:  return f.c;
    3:  return !f.c;
    4:  return f.s;
    5:  return !f.s;
    6:  return f.v;
    7:  return !f.v;
    8:  return f.c && !f.z;
    9:  return !f.c || f.z;
    10: return ge;
    11: return !ge;
    12: return !f.z && ge;
    13: return f.z || !ge;
    14: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

// one request through decode, alu and commit; updates flags in place
function automatic exec_pkg::exec_rsp_t model_step(input exec_pkg::exec_req_t req,
                                                   inout exec_pkg::exec_flags_t flags);
  logic [31:0]           w;
  logic [31:0]           a;
  logic [31:0]           b;
  logic [31:0]           r;
  longint                wide;
  int                    op;
  exec_pkg::exec_flags_t cand;
  exec_pkg::exec_rsp_t   rsp;
  w    = req.insn;
  a    = req.a;
  b    = w[22] ? 32'($signed(w[19:0])) : req.b;
  op   = (w[31:28] > 9) ? 9 : int'(w[31:28]);
  cand = '0;
  case (op)
    0, 1: begin
      wide   = (op == 0) ? longint'($signed(a)) + longint'($signed(b))
                         : longint'($signed(a)) - longint'($signed(b));
      r      = wide[31:0];
      cand.v = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
      cand.c = (op == 0) ? ({1'b0, a} + {1'b0, b}) > 33'h0_ffff_ffff : (a >= b);
    end
    2: r = a & b;
    3: r = a ^ b;
    4: r = a | b;
    5: r = a << b[4:0];
    6: r = a >> b[4:0];
    7: r = $signed(a) >>> b[4:0];
    8: begin
      case (w[21:20])
        2'd0:    r = 32'($signed(a[7:0]));
        2'd1:    r = 32'($signed(a[15:0]));
        2'd2:    r = 32'(a[15:0]);
        default: r = {<<8{a}};
      endcase
    end
    default: r = b;
  endcase
  cand.s = r[31];
  cand.z = (r == 32'd0);
  rsp.executed = model_cond(int'(w[27:24]), flags);
  if (rsp.executed && w[23]) begin
    flags = cand;
  end
  rsp.result = r;
  rsp.flags  = flags;
  return rsp;
endfunction

`endif

/* tb_exec.sv */
// ==============================
// tb_exec: random stimulus and model
// checks for the execute pipeline
// ==============================
module tb_exec;
  import exec_pkg::*;

  `include "tb_model.svh"

  localparam logic [31:0] SEED = 32'h38ec_e72d;
  localparam int N_RESET  = 20;
  localparam int N_ARITH  = 300;
  localparam int N_LOGIC  = 448;  // 14 opcodes x 32 shift amounts
  localparam int N_COND   = 400;
  localparam int N_STREAM = 200;
  localparam int N_STALL  = 400;
  localparam int TOTAL_TXN = N_RESET + N_ARITH + N_LOGIC + N_COND + N_STREAM + N_STALL;

  logic      clk;
  logic      rst;
  logic      in_valid;
  logic      in_ready;
  exec_req_t in_req;
  logic      out_valid;
  logic      out_ready;
  exec_rsp_t out_rsp;

  logic [31:0] stim_state;
  logic [31:0] stall_state;
  exec_flags_t model_flags;
  exec_flags_t last_flags;
  exec_rsp_t   exp_q[$];
  int          acc_q[$];  // accept cycle per item
  int          cycle;
  int          gap_pct;
  int          stall_pct;
  bit          check_lat;
  int          accepted;
  int          received;
  int          checks;
  int          errors;

  exec_top dut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_req   (in_req),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_rsp  (out_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rnd();
    stim_state = lcg_next(stim_state);
    return stim_state;
  endfunction

  function automatic int rnd_pct();
    logic [31:0] r;
    r = rnd();
    return int'(r[31:16]) % 100;
  endfunction

  // corner values often enough to hit overflow and carry
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = rnd();
    case (r[18:16])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'h7fff_ffff;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'hffff_ffff;
      default: return rnd();
    endcase
  endfunction

  function automatic exec_req_t make_req(input int id, input int idx);
    exec_req_t   req;
    logic [31:0] r;
    logic [31:0] r2;
    logic [3:0]  opc;
    logic [3:0]  cond;
    logic        setf;
    logic        immf;
    logic [1:0]  size;
    logic [19:0] low;
    logic [4:0]  amt;
    r    = rnd();
    r2   = rnd();
    opc  = r[31:28];
    cond = r[27:24];
    setf = r[23] | r[19];
    immf = r[22];
    size = r[21:20];
    low  = r2[31:12];
    req.a = pick_operand();
    req.b = pick_operand();
    case (id)
      1: begin
        cond = 4'd14;
        setf = 1'b1;
        if (idx == 0) begin  // mov 0, always, set flags
          opc  = 4'd9;
          immf = 1'b1;
          low  = 20'd0;
        end
      end
      2: begin
        opc  = {3'b000, r[28]};
        cond = 4'd14;
        setf = 1'b1;
      end
      3: begin
        amt   = 5'((idx / 14) % 32);
        opc   = 4'(2 + idx % 14);
        cond  = 4'd14;
        size  = 2'((idx / 14) % 4);
        low   = {low[19:5], amt};
        req.b = {req.b[31:5], amt};
      end
      default: ;
    endcase
    req.insn = {opc, cond, setf, immf, size, low};
    return req;
  endfunction

  task automatic check_rsp(input exec_rsp_t got);
    exec_rsp_t exp;
    int        lat;
    checks++;
    assert (exp_q.size() > 0) else begin
      $display("response arrived with no request outstanding");
      errors++;
    end
    if (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      lat = cycle - acc_q.pop_front();
      assert (got.result == exp.result) else begin
        $display("FAILED out_rsp.result: got %h expected %h", got.result, exp.result);
        errors++;
      end
      assert (got.flags == exp.flags) else begin
        $display("FAILED out_rsp.flags: got %h expected %h", got.flags, exp.flags);
        errors++;
      end
      assert (got.executed == exp.executed) else begin
        $display("FAILED out_rsp.executed: got %h expected %h", got.executed, exp.executed);
        errors++;
      end
      assert (got.executed || got.flags == last_flags) else begin
        $display("suppressed instruction changed the flags");
        errors++;
      end
      if (received == 0) begin
        // flags start at 0, so mov 0 leaves only z
        assert (got.flags == 4'b0001) else begin
          $display("FAILED out_rsp.flags: got %h expected %h", got.flags, 4'b0001);
          errors++;
        end
        assert (got.executed) else begin
          $display("FAILED out_rsp.executed: got %h expected %h", got.executed, 1'b1);
          errors++;
        end
      end
      if (check_lat) begin
        assert (lat == 3) else begin
          $display("response took %0d cycles instead of 3", lat);
          errors++;
        end
      end
      last_flags = got.flags;
    end
    received++;
  endtask

  always @(posedge clk) begin
    if (!rst && in_valid && in_ready) begin
      exp_q.push_back(model_step(in_req, model_flags));
      acc_q.push_back(cycle);
      accepted++;
    end
    if (!rst && check_lat) begin
      // nothing stalls the output, so every offered request goes in
      assert (!in_valid || in_ready) else begin
        $display("in_ready dropped while out_ready was held high");
        errors++;
      end
    end
    if (!rst && out_valid && out_ready) begin
      check_rsp(out_rsp);
    end
    cycle++;
  end

  // back-pressure from its own random stream
  always @(posedge clk) begin
    stall_state = lcg_next(stall_state);
    out_ready <= (int'(stall_state[31:16]) % 100) >= stall_pct;
  end

  task automatic drive_reqs(input int id, input int count);
    for (int i = 0; i < count; i++) begin
      while (rnd_pct() < gap_pct) begin
        in_valid <= 1'b0;
        @(posedge clk);
      end
      in_valid <= 1'b1;
      in_req   <= make_req(id, i);
      @(posedge clk);
      while (!in_ready) @(posedge clk);
    end
    in_valid <= 1'b0;
  endtask

  task automatic run_test(input int id, input string name, input int count,
                          input int gap, input int stall, input bit lat);
    int err0;
    int n0;
    err0      = errors;
    n0        = received;
    gap_pct   = gap;
    stall_pct = stall;
    check_lat = lat;
    drive_reqs(id, count);
    @(posedge clk);
    while (exp_q.size() != 0) @(posedge clk);
    assert (accepted == received) else begin
      $display("accepted %0d requests but got %0d responses", accepted, received);
      errors++;
    end
    $display("test %0d %s: %0d responses, %0d errors", id, name, received - n0,
             errors - err0);
  endtask

  initial begin
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_req      = '0;
    out_ready   = 1'b0;
    stim_state  = SEED;
    stall_state = ~SEED;
    model_flags = '0;
    last_flags  = '0;
    cycle       = 0;
    gap_pct     = 0;
    stall_pct   = 0;
    check_lat   = 1'b0;
    accepted    = 0;
    received    = 0;
    checks      = 0;
    errors      = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    checks++;
    assert (!out_valid) else begin
      $display("out_valid high right after reset");
      errors++;
    end
    run_test(1, "after reset", N_RESET, 20, 20, 1'b0);
    run_test(2, "arithmetic flags", N_ARITH, 20, 20, 1'b0);
    run_test(3, "logic shift sxt", N_LOGIC, 10, 10, 1'b0);
    run_test(4, "conditional execution", N_COND, 20, 30, 1'b0);
    run_test(5, "streaming", N_STREAM, 0, 0, 1'b1);
    run_test(6, "back-pressure", N_STALL, 25, 50, 1'b0);
    $display("checks %0d, errors %0d, requests %0d, responses %0d",
             checks, errors, accepted, received);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (16 + TOTAL_TXN * 40) @(posedge clk);
    $display("timeout after %0d cycles, pipeline stopped making progress", cycle);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* src.f */
+incdir+.
exec_pkg.sv
pipe_stage.sv
exec_decode.sv
exec_shift.sv
exec_alu.sv
exec_commit.sv
exec_top.sv
tb_exec.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_exec
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
